//--- common/cam_noc_pkg.sv
// Camera NoC shared types, flit kinds and header field positions
package cam_noc_pkg;

   // Base widths
   localparam int PIXEL_W = 8;
   localparam int WORD_W  = 32;
   localparam int KIND_W  = 2;
   localparam int FLIT_W  = KIND_W + WORD_W;   // Kind over data

   typedef logic [PIXEL_W-1:0] pixel_t;       // One camera byte
   typedef logic [WORD_W-1:0]  word_t;        // NoC payload word
   typedef logic [KIND_W-1:0]  flit_kind_t;
   typedef logic [FLIT_W-1:0]  flit_t;
   typedef logic [15:0]        line_num_t;    // Line index in frame
   typedef logic [7:0]         frame_num_t;   // Frame counter
   typedef logic [15:0]        count_t;       // Words per line

   // Flit kinds, lisnoc style encoding
   localparam flit_kind_t FLIT_PAYLOAD = 2'b00;
   localparam flit_kind_t FLIT_HEADER  = 2'b01;
   localparam flit_kind_t FLIT_TAIL    = 2'b10;

   // Kind field sits in the top bits of a flit
   localparam int FLIT_KIND_HI = FLIT_W - 1;
   localparam int FLIT_KIND_LO = WORD_W;

   // Header data layout, upper bits stay zero
   localparam int HDR_FRAME_HI = 23;
   localparam int HDR_FRAME_LO = 16;
   localparam int HDR_LINE_HI  = 15;
   localparam int HDR_LINE_LO  = 0;

endpackage

//--- rtl/flit_fifo.sv
// Flit FIFO with valid/ready on both sides, models the NoC link buffer
`timescale 1ns/100ps

module flit_fifo #(
   parameter int FIFO_DEPTH = 4
) (
   input  logic               clk,
   input  logic               reset_i,
   input  cam_noc_pkg::flit_t in_flit_i,
   input  logic               in_valid_i,
   output logic               in_ready_o,
   output cam_noc_pkg::flit_t out_flit_o,
   output logic               out_valid_o,
   input  logic               out_ready_i
);

   localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
   localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

   cam_noc_pkg::flit_t mem [FIFO_DEPTH];
   logic [PTR_W-1:0]   wr_ptr, rd_ptr;
   logic [CNT_W-1:0]   count;   // Occupancy
   logic               push, pop;

   assign in_ready_o  = (count != CNT_W'(FIFO_DEPTH));   // Not full
   assign out_valid_o = (count != '0);                   // Not empty
   assign out_flit_o  = mem[rd_ptr];                     // Head flit
   assign push = in_valid_i && in_ready_o;
   assign pop  = out_valid_o && out_ready_i;

   // Circular increment, depth need not be a power of two
   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
      if (p == PTR_W'(FIFO_DEPTH - 1))
         return '0;
      return p + PTR_W'(1);
   endfunction

   always_ff @(posedge clk) begin
      if (push)
         mem[wr_ptr] <= in_flit_i;
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push)
            wr_ptr <= ptr_inc(wr_ptr);
         if (pop)
            rd_ptr <= ptr_inc(rd_ptr);
         case ({push, pop})
            2'b10:   count <= count + CNT_W'(1);
            2'b01:   count <= count - CNT_W'(1);
            default: ;   // Both or neither, no change
         endcase
      end
   end

endmodule

//--- camera/camera_capture.sv
// Camera bus capture, synchronises PCLK/HREF/VSYNC/D and packs bytes into 32-bit words
`timescale 1ns/100ps

module camera_capture (
   input  logic                clk,
   input  logic                reset_i,
   input  logic                pclk_i,
   input  logic                href_i,
   input  logic                vsync_i,
   input  cam_noc_pkg::pixel_t d_i,
   output cam_noc_pkg::word_t  word_o,
   output logic                word_valid_o,
   output logic                line_end_o,
   output logic                frame_start_o
);

   // Two-flop synchronisers plus previous-value flops for edges
   logic pclk_s1, pclk_s2, pclk_prev;
   logic href_s1, href_s2, href_prev;
   logic vsync_s1, vsync_s2, vsync_prev;
   cam_noc_pkg::pixel_t d_s1, d_s2;

   logic               take_q;     // Byte strobe, delayed PCLK rise
   logic [1:0]         lane;       // Next byte lane, 0 = bits 31:24
   logic               end_pend;   // Line end after padded word
   cam_noc_pkg::word_t acc;        // Partial word
   cam_noc_pkg::word_t acc_next;

   logic pclk_rise, href_fall, vsync_rise;

   assign pclk_rise  = pclk_s2 & ~pclk_prev;
   assign href_fall  = ~href_s2 & href_prev;
   assign vsync_rise = vsync_s2 & ~vsync_prev;

   // Insert synced byte into its lane, fresh word starts from zero
   always_comb begin
      acc_next = (lane == 2'd0) ? '0 : acc;
      acc_next[8*(3-lane) +: 8] = d_s2;
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         {pclk_s1, pclk_s2, pclk_prev}    <= '0;
         {href_s1, href_s2, href_prev}    <= '0;
         {vsync_s1, vsync_s2, vsync_prev} <= '0;
         take_q        <= 1'b0;
         lane          <= '0;
         end_pend      <= 1'b0;
         word_valid_o  <= 1'b0;
         line_end_o    <= 1'b0;
         frame_start_o <= 1'b0;
      end else begin
         pclk_s1  <= pclk_i;
         pclk_s2  <= pclk_s1;
         href_s1  <= href_i;
         href_s2  <= href_s1;
         vsync_s1 <= vsync_i;
         vsync_s2 <= vsync_s1;
         pclk_prev  <= pclk_s2;
         href_prev  <= href_s2;
         vsync_prev <= vsync_s2;
         take_q        <= pclk_rise & href_s2;   // Bytes with HREF low dropped
         word_valid_o  <= 1'b0;
         line_end_o    <= end_pend;
         end_pend      <= 1'b0;
         frame_start_o <= vsync_rise;
         if (vsync_rise) begin
            lane <= '0;                          // Drop stale partial word
         end else if (take_q) begin
            if (lane == 2'd3) begin
               word_valid_o <= 1'b1;             // Word complete
               lane         <= '0;
            end else begin
               lane <= lane + 2'd1;
            end
         end else if (href_fall) begin
            if (lane != 2'd0) begin
               word_valid_o <= 1'b1;             // Padded last word
               end_pend     <= 1'b1;             // Line end one cycle later
               lane         <= '0;
            end else begin
               line_end_o <= 1'b1;
            end
         end
      end
   end

   // Byte and word data path
   always_ff @(posedge clk) begin
      d_s1 <= d_i;
      d_s2 <= d_s1;
      if (take_q) begin
         acc <= acc_next;
         if (lane == 2'd3)
            word_o <= acc_next;
      end else if (href_fall && lane != 2'd0) begin
         word_o <= acc;                          // Low bytes already zero
      end
   end

endmodule

//--- camera/cam_packetizer.sv
// Line packetizer, turns camera words into header, payload and tail flits
`timescale 1ns/100ps

module cam_packetizer (
   input  logic                clk,
   input  logic                reset_i,
   input  cam_noc_pkg::word_t  word_i,
   input  logic                word_valid_i,
   input  logic                line_end_i,
   input  logic                frame_start_i,
   output cam_noc_pkg::flit_t  flit_o,
   output logic                flit_valid_o,
   input  logic                flit_ready_i,
   output logic                overflow_o
);

   typedef enum logic [1:0] {idle, header, payload, tail} state_t;

   state_t state;

   // Two-entry holding queue
   cam_noc_pkg::word_t q_mem [2];
   logic               q_wr, q_rd;
   logic [1:0]         q_cnt;
   logic               q_empty, q_full, push, pop;

   cam_noc_pkg::frame_num_t frame_cnt;
   cam_noc_pkg::line_num_t  line_cnt;
   cam_noc_pkg::count_t     word_cnt;   // Payloads sent this line
   logic                    seen_frame; // First VSYNC seen
   logic                    line_pend;  // Line end waiting for tail
   cam_noc_pkg::word_t      hdr_data;

   assign q_empty = (q_cnt == 2'd0);
   assign q_full  = (q_cnt == 2'd2);
   assign pop     = (state == payload) && !q_empty && flit_ready_i;
   assign push    = word_valid_i && (!q_full || pop);

   always_comb begin
      hdr_data = '0;
      hdr_data[cam_noc_pkg::HDR_FRAME_HI:cam_noc_pkg::HDR_FRAME_LO] = frame_cnt;
      hdr_data[cam_noc_pkg::HDR_LINE_HI:cam_noc_pkg::HDR_LINE_LO]   = line_cnt;
      flit_valid_o = 1'b0;
      flit_o       = {cam_noc_pkg::FLIT_PAYLOAD, q_mem[q_rd]};   // Queue head
      case (state)
         header: begin
            flit_valid_o = 1'b1;
            flit_o       = {cam_noc_pkg::FLIT_HEADER, hdr_data};
         end
         payload: flit_valid_o = !q_empty;
         tail: begin
            flit_valid_o = 1'b1;
            flit_o       = {cam_noc_pkg::FLIT_TAIL, cam_noc_pkg::word_t'(word_cnt)};
         end
         default: ;
      endcase
   end

   // Queue storage
   always_ff @(posedge clk) begin
      if (push)
         q_mem[q_wr] <= word_i;
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         state      <= idle;
         q_wr       <= 1'b0;
         q_rd       <= 1'b0;
         q_cnt      <= '0;
         frame_cnt  <= '0;
         line_cnt   <= '0;
         word_cnt   <= '0;
         seen_frame <= 1'b0;
         line_pend  <= 1'b0;
         overflow_o <= 1'b0;
      end else begin
         if (push) q_wr <= ~q_wr;
         if (pop)  q_rd <= ~q_rd;
         q_cnt <= q_cnt + {1'b0, push} - {1'b0, pop};
         if (word_valid_i && q_full && !pop)
            overflow_o <= 1'b1;                    // Sticky, word lost
         case (state)
            idle: begin
               if (!q_empty) begin
                  state    <= header;              // First word of a line
                  word_cnt <= '0;
               end else if (line_pend) begin
                  line_pend <= 1'b0;               // Empty line, no packet
               end
            end
            header: if (flit_ready_i) state <= payload;
            payload: begin
               if (pop)
                  word_cnt <= word_cnt + 16'd1;
               else if (q_empty && line_pend)
                  state <= tail;                   // Drained, close packet
            end
            tail: begin
               if (flit_ready_i) begin
                  state     <= idle;
                  line_pend <= 1'b0;
                  line_cnt  <= line_cnt + 16'd1;
               end
            end
            default: state <= idle;
         endcase
         if (line_end_i)
            line_pend <= 1'b1;
         if (frame_start_i) begin
            line_cnt   <= '0;                      // Wins over tail increment
            seen_frame <= 1'b1;
            if (seen_frame)
               frame_cnt <= frame_cnt + 8'd1;
         end
      end
   end

endmodule

//--- sink/line_sink.sv
// Line sink, parses camera packets into per-line frame, line, count and checksum
`timescale 1ns/100ps

module line_sink (
   input  logic                    clk,
   input  logic                    reset_i,
   input  cam_noc_pkg::flit_t      flit_i,
   input  logic                    flit_valid_i,
   output logic                    flit_ready_o,
   output logic                    line_done_o,
   output cam_noc_pkg::frame_num_t line_frame_o,
   output cam_noc_pkg::line_num_t  line_num_o,
   output cam_noc_pkg::count_t     line_words_o,
   output cam_noc_pkg::word_t      line_sum_o,
   output logic                    proto_err_o
);

   typedef enum logic {wait_header, in_packet} state_t;

   state_t                  state;
   cam_noc_pkg::flit_kind_t kind;
   cam_noc_pkg::word_t      data;
   cam_noc_pkg::count_t     word_cnt;   // Payloads in current packet
   cam_noc_pkg::word_t      sum;        // Running checksum
   logic                    xfer;

   assign flit_ready_o = 1'b1;           // Never stalls the link
   assign xfer = flit_valid_i && flit_ready_o;
   assign kind = flit_i[cam_noc_pkg::FLIT_KIND_HI:cam_noc_pkg::FLIT_KIND_LO];
   assign data = flit_i[cam_noc_pkg::FLIT_KIND_LO-1:0];

   // Results come straight from the packet registers
   assign line_words_o = word_cnt;
   assign line_sum_o   = sum;

   // Header fields and checksum
   always_ff @(posedge clk) begin
      if (xfer) begin
         if (kind == cam_noc_pkg::FLIT_HEADER) begin
            line_frame_o <= data[cam_noc_pkg::HDR_FRAME_HI:cam_noc_pkg::HDR_FRAME_LO];
            line_num_o   <= data[cam_noc_pkg::HDR_LINE_HI:cam_noc_pkg::HDR_LINE_LO];
            sum          <= '0;
         end else if (kind == cam_noc_pkg::FLIT_PAYLOAD && state == in_packet) begin
            sum <= sum + data;           // Wraps modulo 2^32
         end
      end
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         state       <= wait_header;
         word_cnt    <= '0;
         line_done_o <= 1'b0;
         proto_err_o <= 1'b0;
      end else begin
         line_done_o <= 1'b0;
         if (xfer) begin
            case (kind)
               cam_noc_pkg::FLIT_HEADER: begin
                  if (state == in_packet)
                     proto_err_o <= 1'b1;   // Header inside a packet
                  state    <= in_packet;     // Restart on new header
                  word_cnt <= '0;
               end
               cam_noc_pkg::FLIT_PAYLOAD: begin
                  if (state == in_packet)
                     word_cnt <= word_cnt + 16'd1;
                  else
                     proto_err_o <= 1'b1;   // Stray payload
               end
               cam_noc_pkg::FLIT_TAIL: begin
                  if (state == in_packet) begin
                     state       <= wait_header;
                     line_done_o <= 1'b1;    // Strobe results next cycle
                     if (data != cam_noc_pkg::word_t'(word_cnt))
                        proto_err_o <= 1'b1; // Count mismatch
                  end else begin
                     proto_err_o <= 1'b1;    // Stray tail
                  end
               end
               default: proto_err_o <= 1'b1; // Unknown kind
            endcase
         end
      end
   end

endmodule

//--- rtl/system_cam_noc.sv
// Camera tile to line sink over a single buffered NoC link
`timescale 1ns/100ps

module system_cam_noc #(
   parameter int FIFO_DEPTH = 4
) (
   input  logic                    clk,
   input  logic                    reset_i,
   input  logic                    pclk_i,
   input  logic                    href_i,
   input  logic                    vsync_i,
   input  cam_noc_pkg::pixel_t     d_i,
   output logic                    line_done_o,
   output cam_noc_pkg::frame_num_t line_frame_o,
   output cam_noc_pkg::line_num_t  line_num_o,
   output cam_noc_pkg::count_t     line_words_o,
   output cam_noc_pkg::word_t      line_sum_o,
   output logic                    proto_err_o,
   output logic                    overflow_o
);

   // Capture to packetizer
   cam_noc_pkg::word_t cap_word;
   logic               cap_word_valid, cap_line_end, cap_frame_start;

   // Packetizer to link buffer
   cam_noc_pkg::flit_t tx_flit;
   logic               tx_valid, tx_ready;

   // Link buffer to sink
   cam_noc_pkg::flit_t rx_flit;
   logic               rx_valid, rx_ready;

   camera_capture u_capture (
      .clk           (clk),
      .reset_i       (reset_i),
      .pclk_i        (pclk_i),
      .href_i        (href_i),
      .vsync_i       (vsync_i),
      .d_i           (d_i),
      .word_o        (cap_word),
      .word_valid_o  (cap_word_valid),
      .line_end_o    (cap_line_end),
      .frame_start_o (cap_frame_start)
   );

   cam_packetizer u_packetizer (
      .clk           (clk),
      .reset_i       (reset_i),
      .word_i        (cap_word),
      .word_valid_i  (cap_word_valid),
      .line_end_i    (cap_line_end),
      .frame_start_i (cap_frame_start),
      .flit_o        (tx_flit),
      .flit_valid_o  (tx_valid),
      .flit_ready_i  (tx_ready),
      .overflow_o    (overflow_o)
   );

   flit_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) u_link_fifo (
      .clk         (clk),
      .reset_i     (reset_i),
      .in_flit_i   (tx_flit),
      .in_valid_i  (tx_valid),
      .in_ready_o  (tx_ready),
      .out_flit_o  (rx_flit),
      .out_valid_o (rx_valid),
      .out_ready_i (rx_ready)
   );

   line_sink u_sink (
      .clk          (clk),
      .reset_i      (reset_i),
      .flit_i       (rx_flit),
      .flit_valid_i (rx_valid),
      .flit_ready_o (rx_ready),
      .line_done_o  (line_done_o),
      .line_frame_o (line_frame_o),
      .line_num_o   (line_num_o),
      .line_words_o (line_words_o),
      .line_sum_o   (line_sum_o),
      .proto_err_o  (proto_err_o)
   );

endmodule

//--- tb/system_cam_noc_sva.sv
// Link and result protocol assertions bound into the FIFO and the line sink
`timescale 1ns/100ps

module system_cam_noc_sva (
   input logic               clk,
   input logic               reset_i,
   input cam_noc_pkg::flit_t flit_i,
   input logic               valid_i,
   input logic               ready_i,
   input logic               push_i,   // Buffer write
   input logic               full_i,   // Buffer full
   input logic               done_i,   // Result strobe
   input logic               err_i     // Sticky protocol error
);

   // Stalled flit must not change
   a_flit_held: assert property (@(posedge clk) disable iff (reset_i)
      valid_i && !ready_i |=> valid_i && $stable(flit_i))
      else $error("flit dropped or changed while stalled");

   // One-cycle result strobe
   a_done_pulse: assert property (@(posedge clk) disable iff (reset_i)
      done_i |=> !done_i)
      else $error("line_done_o high for two cycles");

   a_no_push_full: assert property (@(posedge clk) disable iff (reset_i)
      !(push_i && full_i))
      else $error("flit pushed into a full FIFO");

   a_no_proto_err: assert property (@(posedge clk) disable iff (reset_i)
      !$rose(err_i))
      else $error("proto_err_o raised");

endmodule

// Input side of the link buffer where back-pressure exists
bind flit_fifo system_cam_noc_sva u_fifo_sva (
   .clk     (clk),
   .reset_i (reset_i),
   .flit_i  (in_flit_i),
   .valid_i (in_valid_i),
   .ready_i (in_ready_o),
   .push_i  (push),
   .full_i  ((wr_ptr == rd_ptr) && (count != '0)),   // Full as seen from the pointers
   .done_i  (1'b0),
   .err_i   (1'b0)
);

bind line_sink system_cam_noc_sva u_sink_sva (
   .clk     (clk),
   .reset_i (reset_i),
   .flit_i  (flit_i),
   .valid_i (flit_valid_i),
   .ready_i (flit_ready_o),
   .push_i  (1'b0),
   .full_i  (1'b0),
   .done_i  (line_done_o),
   .err_i   (proto_err_o)
);

//--- tb/tb_system_cam_noc.sv
// Testbench for the camera NoC path, replays camera lines from a file and checks each line result
`timescale 1ns/100ps

module tb_system_cam_noc;

   localparam int STIM_DEPTH   = 256;
   localparam int LINE_TIMEOUT = 500;   // clk cycles allowed from HREF fall to line_done_o

   logic                    clk;
   logic                    reset_i;
   logic                    pclk_i, href_i, vsync_i;
   cam_noc_pkg::pixel_t     d_i;
   logic                    line_done_o;
   cam_noc_pkg::frame_num_t line_frame_o;
   cam_noc_pkg::line_num_t  line_num_o;
   cam_noc_pkg::count_t     line_words_o;
   cam_noc_pkg::word_t      line_sum_o;
   logic                    proto_err_o, overflow_o;

   logic [31:0] stim [STIM_DEPTH];   // Stimulus records, see file header
   int          ptr;                 // Current record
   int          lines_checked;

   system_cam_noc #(.FIFO_DEPTH(4)) dut0 (
      .clk          (clk),
      .reset_i      (reset_i),
      .pclk_i       (pclk_i),
      .href_i       (href_i),
      .vsync_i      (vsync_i),
      .d_i          (d_i),
      .line_done_o  (line_done_o),
      .line_frame_o (line_frame_o),
      .line_num_o   (line_num_o),
      .line_words_o (line_words_o),
      .line_sum_o   (line_sum_o),
      .proto_err_o  (proto_err_o),
      .overflow_o   (overflow_o)
   );

   always #20 clk = ~clk;   // 40 ns period

   task automatic end_with_failure();
      $display("Simulation finished: FAIL");
      $fatal(1);
   endtask

   task automatic check_flag(input string name, input string sig, input logic exp, input logic act);
      if (act !== exp) begin
         $display("[ERROR] %s: %s expected %b, actual %b", name, sig, exp, act);
         end_with_failure();
      end
   endtask

   task automatic check_count(input string name, input cam_noc_pkg::count_t exp,
                              input cam_noc_pkg::count_t act);
      if (act !== exp) begin
         $display("[ERROR] %s: word count expected %0d, actual %0d", name, exp, act);
         end_with_failure();
      end
   endtask

   task automatic check_sum(input string name, input cam_noc_pkg::word_t exp,
                            input cam_noc_pkg::word_t act);
      if (act !== exp) begin
         $display("[ERROR] %s: checksum expected %h, actual %h", name, exp, act);
         end_with_failure();
      end
   endtask

   task automatic check_line(input string name, input cam_noc_pkg::line_num_t exp,
                             input cam_noc_pkg::line_num_t act);
      if (act !== exp) begin
         $display("[ERROR] %s: line number expected %0d, actual %0d", name, exp, act);
         end_with_failure();
      end
   endtask

   task automatic check_frame(input string name, input cam_noc_pkg::frame_num_t exp,
                              input cam_noc_pkg::frame_num_t act);
      if (act !== exp) begin
         $display("[ERROR] %s: frame number expected %0d, actual %0d", name, exp, act);
         end_with_failure();
      end
   endtask

   // Status outputs that must stay quiet
   task automatic check_quiet(input string name);
      check_flag(name, "line_done_o", 1'b0, line_done_o);
      check_flag(name, "proto_err_o", 1'b0, proto_err_o);
      check_flag(name, "overflow_o", 1'b0, overflow_o);
   endtask

   // Idle clk cycles, no line may complete meanwhile
   task automatic idle_cycles(input int n);
      repeat (n) begin
         @(negedge clk);
         if (line_done_o !== 1'b0) begin
            $display("line_done_o pulsed while no line was pending");
            end_with_failure();
         end
      end
   endtask

   // One PCLK period, low phase then high phase, random length per level
   task automatic drive_byte(input cam_noc_pkg::pixel_t b, input logic href);
      int low_cycles;
      int high_cycles;
      low_cycles  = 3 + ($urandom % 4);
      high_cycles = 3 + ($urandom % 4);
      d_i    = b;
      href_i = href;
      pclk_i = 1'b0;
      idle_cycles(low_cycles);
      pclk_i = 1'b1;   // Byte taken on this rise
      idle_cycles(high_cycles);
   endtask

   task automatic wait_line_done(input string name);
      int waited;
      waited = 0;
      @(negedge clk);
      while (line_done_o !== 1'b1) begin
         if (waited >= LINE_TIMEOUT) begin
            $display("Timeout: %s got no line_done_o within %0d cycles", name, LINE_TIMEOUT);
            end_with_failure();
         end
         waited++;
         @(negedge clk);
      end
   endtask

   task automatic frame_pulse();
      vsync_i = 1'b1;
      idle_cycles(4);
      vsync_i = 1'b0;
      idle_cycles(4);
      ptr = ptr + 1;
   endtask

   // Bytes with HREF low, the DUT must drop them
   task automatic play_skip();
      int nbytes;
      int i;
      nbytes = stim[ptr+1];
      for (i = 0; i < nbytes; i++)
         drive_byte(stim[ptr+2+i][7:0], 1'b0);
      pclk_i = 1'b0;
      idle_cycles(6);
      ptr = ptr + 2 + nbytes;
   endtask

   task automatic play_line();
      int    nbytes;
      int    i;
      int    res;   // First expected value
      string name;
      nbytes = stim[ptr+1];
      res    = ptr + 2 + nbytes;
      name   = $sformatf("line record %0d", lines_checked);
      if (res + 4 > STIM_DEPTH) begin
         $display("Stimulus file ends inside a line record");
         end_with_failure();
      end
      for (i = 0; i < nbytes; i++)
         drive_byte(stim[ptr+2+i][7:0], 1'b1);
      href_i = 1'b0;   // Line end
      pclk_i = 1'b0;
      wait_line_done(name);
      check_frame(name, stim[res][7:0], line_frame_o);
      check_line(name, stim[res+1][15:0], line_num_o);
      check_count(name, stim[res+2][15:0], line_words_o);
      check_count(name, cam_noc_pkg::count_t'((nbytes + 3) / 4), line_words_o);   // Rounded up
      check_sum(name, stim[res+3], line_sum_o);
      check_flag(name, "proto_err_o", 1'b0, proto_err_o);
      check_flag(name, "overflow_o", 1'b0, overflow_o);
      lines_checked++;
      ptr = res + 4;
      idle_cycles(6);
   endtask

   initial begin
      int unsigned seed_val;
      logic        running;
      clk           = 1'b0;
      reset_i       = 1'b1;
      pclk_i        = 1'b0;
      href_i        = 1'b0;
      vsync_i       = 1'b0;
      d_i           = '0;
      ptr           = 0;
      lines_checked = 0;
      seed_val      = $urandom(32'h537c);
      $readmemh("tb/cam_stimulus.txt", stim);

      // Reset for two cycles, outputs quiet throughout
      repeat (2) begin
         @(negedge clk);
         check_quiet("reset");
      end
      reset_i = 1'b0;
      @(negedge clk);
      check_quiet("after reset");
      idle_cycles(4);

      running = 1'b1;
      while (running) begin
         if (ptr >= STIM_DEPTH) begin
            $display("Stimulus file has no end record");
            end_with_failure();
         end
         case (stim[ptr])
            32'h1:   frame_pulse();
            32'h2:   play_line();
            32'h3:   play_skip();
            32'hF:   running = 1'b0;
            default: begin
               $display("Unknown record type %h at stimulus entry %0d", stim[ptr], ptr);
               end_with_failure();
            end
         endcase
      end

      if (proto_err_o !== 1'b0 || overflow_o !== 1'b0 || lines_checked == 0) begin
         $display("Error flag set at end of run or no line was checked");
         end_with_failure();
      end else begin
         $display("Simulation finished: PASS");
         $finish;
      end
   end

endmodule

//--- tb/cam_stimulus.txt
// Records, all hex: 1 = VSYNC pulse; 3 = HREF low bytes: count, bytes
// 2 = line: byte count, bytes, then expected frame, line number, word count, checksum; F = end

// Frame 0, full and partial words
1
2 8 01 02 03 04 05 06 07 08
  00 0000 0002 06080A0C
2 C 10 20 30 40 11 22 33 44 FF FF FF FF
  00 0001 0003 21426383
// Checksum wraps past 2^32
2 5 A1 B2 C3 D4 E5
  00 0002 0002 86B2C3D4

// Frame 1, bytes with HREF low between lines
1
2 6 80 00 00 01 7F FE
  01 0000 0002 FFFE0001
3 3 DE AD BE
2 4 12 34 56 78
  01 0001 0001 12345678
2 7 9A BC DE F0 01 02 03
  01 0002 0002 9BBEE1F0

// Frame 2, stray bytes before the first line
1
3 2 55 AA
2 1 C3
  02 0000 0001 C3000000
2 10 00 01 02 03 04 05 06 07 08 09 0A 0B 0C 0D 0E 0F
  02 0001 0004 181C2024
2 3 FF FF FF
  02 0002 0001 FFFFFF00

// Frame 3, all-ones words and a single-byte tail word
1
2 8 FF FF FF FF FF FF FF FF
  03 0000 0002 FFFFFFFE
2 9 01 00 00 00 02 00 00 00 03
  03 0001 0003 06000000

F

//--- flist.f
common/cam_noc_pkg.sv
rtl/flit_fifo.sv
camera/camera_capture.sv
camera/cam_packetizer.sv
sink/line_sink.sv
rtl/system_cam_noc.sv
tb/system_cam_noc_sva.sv
tb/tb_system_cam_noc.sv
